// File: design/fetchPkg.sv
// shared types for the fetch front end
// window halfwords are packed low first, so the first halfword sits in window[15:0]
package fetchPkg;

	// L2 status, driven back by the memory side
	typedef enum logic [1:0]
	{
		okReady = 2'b00, // idle
		okOk    = 2'b01, // data valid this cycle
		okHold  = 2'b10  // busy, keep request up
	} memOk_t;

	typedef enum logic [4:0]
	{
		opmReady  = 5'h00,
		opmRdTile = 5'h0F // one 256-bit tile
	} memOpm_t;

	typedef struct packed
	{
		logic [5:0] prefix; // length bits
		logic [9:0] rest;
	} hwFields_t;

	// one instruction halfword, raw or split for length decode
	typedef union packed
	{
		logic [15:0] raw;
		hwFields_t   f;
	} halfword_u;

	typedef logic [1:0] opLen_t; // halfwords, 1 to 3

	typedef struct packed
	{
		logic [47:0] addr;
		memOpm_t     opm;
	} memReq_t;

	typedef struct packed
	{
		logic [255:0] data;
		memOk_t       ok;
	} memResp_t;

	typedef struct packed
	{
		logic [47:0] pc;
		logic [47:0] window; // three halfwords
		opLen_t      len;
	} fetchBundle_t;

	localparam int tileWords = 16; // halfwords per tile

endpackage

// File: design/fetchPcSeq.sv
// fetch PC register, halfword granular
// redirect wins over an accept in the same cycle
module fetchPcSeq import fetchPkg::*;
#(
	parameter logic [47:0] resetPc = 48'h0
)
(
	input  logic        clock,
	input  logic        rstN,
	input  logic        redirect,
	input  logic [47:0] redirectPc,
	input  logic        accept,
	input  opLen_t      acceptLen,
	output logic [47:0] pc
);

	logic [47:0] pcQ;
	logic [47:0] stepBytes;
	logic [47:0] pcNext;

	// length is in halfwords, step is bytes
	assign stepBytes = {45'd0, acceptLen, 1'b0};

	always_comb
	begin
		pcNext = pcQ;
		if (redirect)
		begin
			pcNext = redirectPc;
		end
		else if (accept)
		begin
			pcNext = pcQ + stepBytes;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			pcQ <= resetPc;
		end
		else
		begin
			pcQ <= pcNext;
		end
	end

	assign pc = pcQ;

endmodule

// File: design/opLenDecode.sv
// instruction length for every halfword of the tile
// crossEnd marks the halfwords whose instruction runs off the tile
module opLenDecode import fetchPkg::*;
(
	input  logic [255:0]                 tileData,
	output opLen_t [tileWords-1:0]       lenVec,
	output logic [1:0]                   crossEnd
);

	halfword_u [tileWords-1:0] tileHw;

	// top six bits of the halfword pick the length
	function automatic opLen_t lenOf(input halfword_u hw);
		opLen_t len;
		casez (hw.f.prefix)
			6'b111111: len = 2'd3;
			6'b111110: len = 2'd2;
			6'b11110?: len = 2'd2;
			default:   len = 2'd1;
		endcase
		return len;
	endfunction

	assign tileHw = tileData;

	always_comb
	begin
		for (int i = 0; i < tileWords; i++)
		begin
			lenVec[i] = lenOf(tileHw[i]);
		end
	end

	// hw14 only fits up to two, hw15 only one
	assign crossEnd[0] = (lenVec[14] == 2'd3);
	assign crossEnd[1] = (lenVec[15] >= 2'd2);

endmodule

// File: design/icacheTile.sv
// single tile I-cache, 32 bytes from a 16-byte aligned line
// pc bit 0 is ignored, instructions are halfword aligned
// an instruction that runs past the tile end refills from its own line
module icacheTile import fetchPkg::*;
(
	input  logic         clock,
	input  logic         rstN,
	input  logic [47:0]  pc,
	input  memResp_t     memResp,
	output memReq_t      memReq,
	output fetchBundle_t hitBundle,
	output logic         hit
);

	logic [255:0] tileData;
	logic [43:0]  baseLine; // line number of the tile's low half
	logic         tileValid;

	memOpm_t      reqOpm;
	logic [47:0]  reqAddr;
	logic         reqBusy;
	logic         respOk;

	logic [43:0]  pcLine;
	logic [43:0]  nextLine;
	logic         inBase;
	logic         inNext;
	logic [3:0]   wordIx;
	logic         crossMiss;
	logic         miss;

	opLen_t [tileWords-1:0] lenVec;
	logic [1:0]             crossEnd;
	halfword_u [tileWords-1:0] tileHw;
	logic [47:0]            window;

	opLenDecode uLenDec
	(
		.tileData (tileData),
		.lenVec   (lenVec),
		.crossEnd (crossEnd)
	);

	assign pcLine   = pc[47:4];
	assign nextLine = baseLine + 44'd1;
	assign inBase   = (pcLine == baseLine);
	assign inNext   = (pcLine == nextLine);
	assign wordIx   = {~inBase, pc[3:1]}; // upper half when in the next line

	assign crossMiss = ((wordIx == 4'd14) && crossEnd[0]) ||
		((wordIx == 4'd15) && crossEnd[1]);

	assign miss = !tileValid || !(inBase || inNext) || crossMiss;
	assign hit  = !miss;

	assign reqBusy = (reqOpm == opmRdTile);
	assign respOk  = reqBusy && (memResp.ok == okOk);

	// L2 request, held until okOk
	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			reqOpm    <= opmReady;
			tileValid <= 1'b0;
		end
		else if (reqBusy)
		begin
			if (respOk)
			begin
				reqOpm    <= opmReady;
				tileValid <= 1'b1;
			end
		end
		else if (miss)
		begin
			reqOpm    <= opmRdTile;
			tileValid <= 1'b0; // old tile no longer trusted
		end
	end

	always_ff @(posedge clock)
	begin
		if (!reqBusy && miss)
		begin
			reqAddr <= {pcLine, 4'h0};
		end
		if (respOk)
		begin
			tileData <= memResp.data;
			baseLine <= reqAddr[47:4]; // line that was asked for, not current pc
		end
	end

	assign memReq.addr = reqAddr;
	assign memReq.opm  = reqOpm;

	assign tileHw = tileData;

	// three halfwords from wordIx, zero past the tile end
	always_comb
	begin
		int idx;
		window = '0;
		for (int k = 0; k < 3; k++)
		begin
			idx = int'(wordIx) + k;
			if (idx < tileWords)
			begin
				window[k*16 +: 16] = tileHw[idx].raw;
			end
		end
	end

	assign hitBundle.pc     = pc;
	assign hitBundle.window = window;
	assign hitBundle.len    = lenVec[wordIx];

endmodule

// File: design/fetchOutReg.sv
// one-entry output register with valid/ready
// accept is combinational, the PC steps on the same edge as the load
module fetchOutReg import fetchPkg::*;
(
	input  logic         clock,
	input  logic         rstN,
	input  fetchBundle_t hitBundle,
	input  logic         hit,
	input  logic         outReady,
	output fetchBundle_t outBundle,
	output logic         outValid,
	output logic         accept,
	output opLen_t       acceptLen
);

	logic         full;
	logic         canLoad;
	fetchBundle_t bundleQ;

	assign canLoad   = !full || outReady; // empty, or draining this cycle
	assign accept    = hit && canLoad;
	assign acceptLen = hitBundle.len;

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			full <= 1'b0;
		end
		else if (accept)
		begin
			full <= 1'b1;
		end
		else if (outReady)
		begin
			full <= 1'b0;
		end
	end

	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			bundleQ <= hitBundle;
		end
	end

	assign outValid  = full;
	assign outBundle = bundleQ;

endmodule

// File: design/fetchTop.sv
// fetch front end: PC sequencer, tile cache, output register
// a redirect blocks the load of the old stream's bundle in that cycle
module fetchTop import fetchPkg::*;
#(
	parameter logic [47:0] resetPc = 48'h1000
)
(
	input  logic         clock,
	input  logic         rstN,
	input  logic         redirect,
	input  logic [47:0]  redirectPc,
	output memReq_t      memReq,
	input  memResp_t     memResp,
	output fetchBundle_t outBundle,
	output logic         outValid,
	input  logic         outReady
);

	logic [47:0]  pc;
	fetchBundle_t hitBundle;
	logic         hit;
	logic         hitLoad;
	logic         accept;
	opLen_t       acceptLen;

	assign hitLoad = hit && !redirect; // no stale bundle on redirect

	fetchPcSeq #(.resetPc(resetPc)) uPcSeq
	(
		.clock      (clock),
		.rstN       (rstN),
		.redirect   (redirect),
		.redirectPc (redirectPc),
		.accept     (accept),
		.acceptLen  (acceptLen),
		.pc         (pc)
	);

	icacheTile uTile
	(
		.clock     (clock),
		.rstN      (rstN),
		.pc        (pc),
		.memResp   (memResp),
		.memReq    (memReq),
		.hitBundle (hitBundle),
		.hit       (hit)
	);

	fetchOutReg uOutReg
	(
		.clock     (clock),
		.rstN      (rstN),
		.hitBundle (hitBundle),
		.hit       (hitLoad),
		.outReady  (outReady),
		.outBundle (outBundle),
		.outValid  (outValid),
		.accept    (accept),
		.acceptLen (acceptLen)
	);

endmodule

// File: verif/fetchProps.sv
// port checks for the fetch front end, bound onto fetchTop
// reset is synchronous, so outValid is checked one edge after rstN low
module fetchProps import fetchPkg::*;
(
	input logic         clock,
	input logic         rstN,
	input memReq_t      memReq,
	input memResp_t     memResp,
	input fetchBundle_t outBundle,
	input logic         outValid,
	input logic         outReady
);

	int failCount = 0;

	// request frozen until L2 says okOk
	reqStable: assert property (@(posedge clock) disable iff (!rstN)
		(memReq.opm == opmRdTile && memResp.ok != okOk) |=> $stable(memReq))
	else
	begin
		failCount++;
		$error("memReq changed while waiting for okOk");
	end

	outStable: assert property (@(posedge clock) disable iff (!rstN)
		(outValid && !outReady) |=> (outValid && $stable(outBundle)))
	else
	begin
		failCount++;
		$error("outBundle changed or dropped while stalled");
	end

	resetIdle: assert property (@(posedge clock) !rstN |=> !outValid)
	else
	begin
		failCount++;
		$error("outValid high during reset");
	end

endmodule

bind fetchTop fetchProps uProps
(
	.clock     (clock),
	.rstN      (rstN),
	.memReq    (memReq),
	.memResp   (memResp),
	.outBundle (outBundle),
	.outValid  (outValid),
	.outReady  (outReady)
);

// File: verif/fetchTb.sv
// testbench for fetchTop, L2 modelled as a fixed pseudo random memory
// each row redirects, collects its bundles, then stalls until the DUT is idle
// the bundle left in the output register leads the next row
module fetchTb import fetchPkg::*;
();

	typedef struct
	{
		logic [47:0] startPc;
		int          count;
		logic [15:0] readyPat; // outReady per cycle, rotating
	} stimRow_t;

	localparam logic [47:0] resetPc = 48'h1000;
	localparam int numRows = 6;
	localparam int watchdogCycles = (numRows + 1) * 200;

	logic         clock;
	logic         rstN;
	logic         redirect;
	logic [47:0]  redirectPc;
	memReq_t      memReq;
	memResp_t     memResp;
	fetchBundle_t outBundle;
	logic         outValid;
	logic         outReady;

	stimRow_t     stimTable [numRows];
	fetchBundle_t expQ [$];
	logic [47:0]  reqQ [$]; // line addresses L2 should see, in order
	logic         refValid;
	logic [43:0]  refBase;  // tile base line as the model sees it
	logic [31:0]  rngState;

	fetchTop #(.resetPc(resetPc)) uut
	(
		.clock      (clock),
		.rstN       (rstN),
		.redirect   (redirect),
		.redirectPc (redirectPc),
		.memReq     (memReq),
		.memResp    (memResp),
		.outBundle  (outBundle),
		.outValid   (outValid),
		.outReady   (outReady)
	);

	function automatic logic [31:0] lcgStep(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// halfword at a byte address, biased so that long instructions are common
	function automatic logic [15:0] memHw(input logic [47:0] addr);
		logic [31:0] s;
		logic [15:0] hw;
		s = 32'd26 ^ addr[32:1] ^ {17'd0, addr[47:33]};
		s = lcgStep(lcgStep(s));
		hw = s[31:16];
		case (s[13:12])
			2'd0: hw[15:10] = 6'b111111;
			2'd1: hw[15:10] = s[11] ? 6'b111110 : {5'b11110, s[10]};
			default: ;
		endcase
		return hw;
	endfunction

	function automatic opLen_t refLen(input logic [15:0] hw);
		if (hw[15:10] == 6'b111111)
			return 2'd3;
		if (hw[15:10] == 6'b111110 || hw[15:11] == 5'b11110)
			return 2'd2;
		return 2'd1;
	endfunction

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic checkBundle(input fetchBundle_t got, input fetchBundle_t exp);
		if (got !== exp)
			failRun($sformatf({"Mismatch at %0t: bundle pc %h len %0d window %h, ",
				"expected pc %h len %0d window %h"},
				$time, got.pc, got.len, got.window, exp.pc, exp.len, exp.window));
	endtask

	task automatic checkMemReq(input memReq_t got, input memReq_t exp);
		if (got !== exp)
			failRun($sformatf("Mismatch at %0t: L2 request addr %h opm %h, expected addr %h opm %h",
				$time, got.addr, got.opm, exp.addr, exp.opm));
	endtask

	task automatic checkFlag(input string what, input logic got, input logic exp);
		if (got !== exp)
			failRun($sformatf("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp));
	endtask

	// walks count+2 instructions, the last one only moves the tile
	task automatic modelStream(input logic [47:0] startPc, input int count);
		logic [47:0]  pc;
		logic [43:0]  line;
		opLen_t       len;
		fetchBundle_t b;
		int           ix;
		int           i;
		int           k;
		pc = startPc;
		for (i = 0; i < count + 2; i++)
		begin
			line = pc[47:4];
			len = refLen(memHw(pc));
			if (refValid && line == refBase)
				ix = pc[3:1];
			else if (refValid && line == refBase + 44'd1)
				ix = 8 + pc[3:1];
			else
				ix = -1;
			if (ix < 0 || ix + len > 16) // outside, or runs past the tile end
			begin
				reqQ.push_back({line, 4'h0});
				refBase = line;
				refValid = 1'b1;
				ix = pc[3:1];
			end
			b.pc = pc;
			b.len = len;
			for (k = 0; k < 3; k++)
				b.window[k*16 +: 16] = (ix + k < 16) ? memHw(pc + 48'(2 * k)) : 16'h0;
			if (i <= count)
				expQ.push_back(b);
			pc = pc + 48'(2 * int'(len));
		end
	endtask

	task automatic collectBundles(input int need, input logic [15:0] pat);
		int got;
		int bitIx;
		got = 0;
		bitIx = 0;
		while (got < need)
		begin
			@(negedge clock);
			if (outValid && outReady)
			begin
				if (expQ.size() == 0)
					failRun("A bundle arrived when none was expected");
				checkBundle(outBundle, expQ.pop_front());
				got++;
			end
			@(posedge clock);
			if (got >= need)
				outReady <= 1'b0; // stall, keep one bundle for the next row
			else
			begin
				outReady <= pat[bitIx];
				bitIx = (bitIx + 1) % 16;
			end
		end
	endtask

	// register full and no refill started for two cycles
	task automatic waitIdle();
		int quiet;
		quiet = 0;
		while (quiet < 2)
		begin
			@(negedge clock);
			if (outValid && memReq.opm == opmReady)
				quiet++;
			else
				quiet = 0;
		end
	endtask

	task automatic serveTile();
		memReq_t      expReq;
		logic [255:0] data;
		int           holdCycles;
		int           i;
		if (reqQ.size() == 0)
			failRun($sformatf("L2 request for %h arrived with no refill expected", memReq.addr));
		expReq.addr = reqQ.pop_front();
		expReq.opm = opmRdTile;
		checkMemReq(memReq, expReq);
		for (i = 0; i < 16; i++)
			data[i*16 +: 16] = memHw(memReq.addr + 48'(2 * i));
		rngState = lcgStep(rngState);
		holdCycles = int'(rngState[31:16] % 6);
		repeat (holdCycles)
		begin
			@(posedge clock);
			memResp.ok <= okHold;
		end
		@(posedge clock);
		memResp.data <= data;
		memResp.ok <= okOk;
		@(posedge clock);
		memResp.data <= '0;
		memResp.ok <= okReady;
	endtask

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	initial
	begin
		repeat (watchdogCycles) @(posedge clock);
		failRun($sformatf("Timeout, the run did not finish within %0d cycles", watchdogCycles));
	end

	initial
	begin
		wait (uut.uProps.failCount != 0);
		failRun("A bound assertion failed, see the error above");
	end

	// L2 side
	initial
	begin
		wait (rstN === 1'b1);
		forever
		begin
			@(negedge clock);
			if (memReq.opm == opmRdTile)
				serveTile();
			else if (memReq.opm != opmReady)
				failRun("L2 request with an unknown operation code");
		end
	end

	initial
	begin
		rstN = 1'b0;
		redirect = 1'b0;
		redirectPc = '0;
		memResp = '0;
		outReady = 1'b0;
		rngState = 32'd26;
		refValid = 1'b0;
		refBase = '0;
		stimTable[0] = '{48'h0000_0000_1000, 24, 16'hFFFF}; // same line as reset
		stimTable[1] = '{48'h0000_0000_2346, 30, 16'hFFFF};
		stimTable[2] = '{48'h0000_0001_7F0C, 20, 16'hB6D5};
		stimTable[3] = '{48'h0000_0000_1024, 24, 16'h00FF};
		stimTable[4] = '{48'h0ABC_DEF0_001C, 20, 16'h5555};
		stimTable[5] = '{48'h0000_0000_2346, 30, 16'hCCCF};
		modelStream(resetPc, 0); // DUT fetches from resetPc on its own
		repeat (2) @(posedge clock);
		rstN <= 1'b1;
		@(negedge clock);
		checkFlag("outValid after reset", outValid, 1'b0);
		checkFlag("L2 request after reset", memReq.opm == opmRdTile, 1'b0);
		for (int r = 0; r < numRows; r++)
		begin
			waitIdle();
			modelStream(stimTable[r].startPc, stimTable[r].count);
			@(posedge clock);
			redirect <= 1'b1;
			redirectPc <= stimTable[r].startPc;
			@(posedge clock);
			redirect <= 1'b0;
			collectBundles(stimTable[r].count + 1, stimTable[r].readyPat);
		end
		waitIdle();
		if (reqQ.size() != 0)
			failRun("An expected L2 refill was never requested");
		if (uut.uProps.failCount == 0)
		begin
			$display("Test OK");
			$finish;
		end
		else
			failRun("A bound assertion failed during the run");
	end

endmodule

// File: all.f
design/fetchPkg.sv
design/fetchPcSeq.sv
design/opLenDecode.sv
design/icacheTile.sv
design/fetchOutReg.sv
design/fetchTop.sv
verif/fetchProps.sv
verif/fetchTb.sv

// File: Bender.yml
package:
  name: fetch_front

sources:
  - files:
      - design/fetchPkg.sv
      - design/fetchPcSeq.sv
      - design/opLenDecode.sv
      - design/icacheTile.sv
      - design/fetchOutReg.sv
      - design/fetchTop.sv
  - target: test
    files:
      - verif/fetchProps.sv
      - verif/fetchTb.sv
